//--- build.f
+incdir+sim
hw/alu_pkg.sv
hw/alu_mul.sv
hw/alu_submodule.sv
hw/alu.sv
sim/alu_tb.sv

//--- hw/alu.sv
`timescale 1ns/1ps

module alu
   import alu_pkg::*;
#(
   parameter int PARALLEL_IF_NUM = 4
)
(
   input  logic                              clk,
   input  logic                              rst_n_i,

   // Per-lane requests, only lane 0 is used in 32 bit multiply mode
   input  logic [PARALLEL_IF_NUM-1:0][8:0]   alu_opmode_i,
   input  logic [PARALLEL_IF_NUM-1:0][31:0]  alu_a_i,
   input  logic [PARALLEL_IF_NUM-1:0][31:0]  alu_b_i,
   input  logic [PARALLEL_IF_NUM-1:0][31:0]  alu_c_i,
   input  sew_e                              sew_i,
   input  logic [PARALLEL_IF_NUM-1:0]        alu_reduction_i,
   input  logic [PARALLEL_IF_NUM-1:0]        alu_vld_i,

   // Slower full width multiply
   input  logic                              alu_en_32bit_mul_i,
   input  logic                              alu_stall_i,

   output logic [PARALLEL_IF_NUM-1:0][31:0]  alu_o,
   output logic [PARALLEL_IF_NUM-1:0]        alu_vld_o,
   output logic [PARALLEL_IF_NUM-1:0]        alu_mask_vector_o
);

   alu_lane_req_t [PARALLEL_IF_NUM-1:0]      lane_req;
   logic [PARALLEL_IF_NUM-1:0]               lane_vld;
   logic [PARALLEL_IF_NUM-1:0][31:0]         lane_res;

   for (genvar i = 0; i < PARALLEL_IF_NUM; i++)
   begin : g_lane
      assign lane_req[i] = {alu_opmode_i[i], alu_a_i[i], alu_b_i[i], alu_c_i[i],
                            alu_reduction_i[i]};

      // Upper lanes are idle in wide multiply mode
      assign lane_vld[i] = alu_vld_i[i] & ((i == 0) | ~alu_en_32bit_mul_i);

      alu_submodule u_lane
      (
         .clk            (clk),
         .rst_n_i        (rst_n_i),
         .req_i          (lane_req[i]),
         .vld_i          (lane_vld[i]),
         .sew_i          (sew_i),
         .en_32bit_mul_i (alu_en_32bit_mul_i),
         .stall_i        (alu_stall_i),
         .result_o       (lane_res[i]),
         .vld_o          (alu_vld_o[i])
      );
   end

   // Compare results land in bit 0
   always_comb
   begin
      for (int i = 0; i < PARALLEL_IF_NUM; i++)
         alu_mask_vector_o[i] = lane_res[i][0];
   end

   // Replicate the low element across the word
   always_comb
   begin
      for (int i = 0; i < PARALLEL_IF_NUM; i++)
      begin
         case (sew_i)
            SEW_8:   alu_o[i] = {4{lane_res[i][7:0]}};
            SEW_16:  alu_o[i] = {2{lane_res[i][15:0]}};
            default: alu_o[i] = lane_res[i];
         endcase
      end
   end

endmodule

//--- hw/alu_mul.sv
`timescale 1ns/1ps

module alu_mul
(
   input  logic        clk,
   input  logic        rst_n_i,
   input  logic        en_i,
   input  logic        wide_i,
   input  logic        sgn_i,
   input  logic [31:0] a_i,
   input  logic [31:0] b_i,
   output logic [31:0] p_o
);

   logic        ext_sgn;
   logic [31:0] ll_full;
   logic [15:0] hl_full;
   logic [15:0] lh_full;

   logic [31:0] ll_s1;
   logic [15:0] hl_s1;
   logic [15:0] lh_s1;
   logic [31:0] ll_s2;
   logic [15:0] cross_s2;
   logic [31:0] sum_s3;

   // The low partial product is unsigned when it is part of a wide multiply
   assign ext_sgn = sgn_i & ~wide_i;

   // Extending to 32 bits gives the signed or unsigned 16x16 product in the low word
   assign ll_full = {{16{ext_sgn & a_i[15]}}, a_i[15:0]} *
                    {{16{ext_sgn & b_i[15]}}, b_i[15:0]};

   // Cross terms only need the low half that lands in the result word
   assign hl_full = a_i[31:16] * b_i[15:0];
   assign lh_full = a_i[15:0] * b_i[31:16];

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         ll_s1    <= '0;
         hl_s1    <= '0;
         lh_s1    <= '0;
         ll_s2    <= '0;
         cross_s2 <= '0;
         sum_s3   <= '0;
      end
      else if (en_i)
      begin
         ll_s1    <= ll_full;
         hl_s1    <= hl_full;
         lh_s1    <= lh_full;
         ll_s2    <= ll_s1;
         cross_s2 <= hl_s1 + lh_s1;
         // Third stage is only meaningful in wide mode
         sum_s3   <= ll_s2 + {cross_s2, 16'h0000};
      end
   end

   assign p_o = wide_i ? sum_s3 : ll_s2;

endmodule

//--- hw/alu_pkg.sv
package alu_pkg;

   // Element width codes, code 3 behaves as 32 bit
   typedef enum logic [1:0]
   {
      SEW_8  = 2'b00,
      SEW_16 = 2'b01,
      SEW_32 = 2'b10
   } sew_e;

   // Compare conditions, unused codes give a zero result
   typedef enum logic [2:0]
   {
      CMP_EQ = 3'd0,
      CMP_NE = 3'd1,
      CMP_LT = 3'd2,
      CMP_LE = 3'd3,
      CMP_GT = 3'd4,
      CMP_GE = 3'd5
   } cmp_cond_e;

   // Arithmetic view of the opmode word (class 0)
   typedef struct packed
   {
      logic       cls;
      logic       mul_en;
      logic       c_en;
      logic       sub;
      logic       sgn;
      logic [3:0] rsvd;
   } alu_arith_op_t;

   // Compare view of the opmode word (class 1)
   typedef struct packed
   {
      logic       cls;
      cmp_cond_e  cond;
      logic       sgn;
      logic [3:0] rsvd;
   } alu_cmp_op_t;

   typedef union packed
   {
      alu_arith_op_t arith;
      alu_cmp_op_t   cmp;
   } alu_opmode_u;

   // One lane request, 106 bits
   typedef struct packed
   {
      alu_opmode_u opmode;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      logic        reduction;
   } alu_lane_req_t;

   // Multiplier stage counts
   localparam int MUL16_LAT = 2;
   localparam int MUL32_LAT = 3;

endpackage

//--- hw/alu_submodule.sv
`timescale 1ns/1ps

module alu_submodule
   import alu_pkg::*;
(
   input  logic          clk,
   input  logic          rst_n_i,
   input  alu_lane_req_t req_i,
   input  logic          vld_i,
   input  sew_e          sew_i,
   input  logic          en_32bit_mul_i,
   input  logic          stall_i,
   output logic [31:0]   result_o,
   output logic          vld_o
);

   logic                                 sgn;
   alu_lane_req_t                        ext_req;
   alu_lane_req_t [MUL32_LAT-1:0]        line_q;
   logic [MUL32_LAT-1:0]                 vld_line_q;

   alu_lane_req_t                        ctl;
   logic                                 ctl_vld;
   logic [31:0]                          mul_p;
   logic [31:0]                          prod;
   logic [31:0]                          addend;
   logic [31:0]                          arith_res;
   logic                                 cmp_bit;
   logic [31:0]                          lane_res;
   logic [31:0]                          acc_q;

   // Truncate to the element width, then extend
   function automatic logic [31:0] sew_ext(input logic [31:0] v,
                                           input sew_e        sew,
                                           input logic        s);
      case (sew)
         SEW_8:   return {{24{s & v[7]}}, v[7:0]};
         SEW_16:  return {{16{s & v[15]}}, v[15:0]};
         default: return v;
      endcase
   endfunction

   function automatic logic cmp_eval(input cmp_cond_e   cond,
                                     input logic        s,
                                     input logic [31:0] a,
                                     input logic [31:0] b);
      logic lt;
      logic eq;
      lt = s ? ($signed(a) < $signed(b)) : (a < b);
      eq = (a == b);
      case (cond)
         CMP_EQ:  return eq;
         CMP_NE:  return ~eq;
         CMP_LT:  return lt;
         CMP_LE:  return lt | eq;
         CMP_GT:  return ~(lt | eq);
         CMP_GE:  return ~lt;
         default: return 1'b0;
      endcase
   endfunction

   // Signed flag is bit 4 in both opmode views
   assign sgn = req_i.opmode.arith.sgn;

   always_comb
   begin
      ext_req   = req_i;
      ext_req.a = sew_ext(req_i.a, sew_i, sgn);
      ext_req.b = sew_ext(req_i.b, sew_i, sgn);
      ext_req.c = sew_ext(req_i.c, sew_i, sgn);
   end

   // Multiplier stage 1 runs alongside the operand stage
   alu_mul u_mul
   (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .en_i    (~stall_i),
      .wide_i  (en_32bit_mul_i),
      .sgn_i   (sgn),
      .a_i     (ext_req.a),
      .b_i     (ext_req.b),
      .p_o     (mul_p)
   );

   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         vld_line_q <= '0;
      else if (!stall_i)
         vld_line_q <= {vld_line_q[MUL32_LAT-2:0], vld_i};
   end

   // Operand stage followed by control delay matching the multiplier
   always_ff @(posedge clk)
   begin
      if (!stall_i)
      begin
         line_q[0] <= ext_req;
         for (int i = 1; i < MUL32_LAT; i++)
            line_q[i] <= line_q[i-1];
      end
   end

   // Tap depends on the multiply mode
   assign ctl     = en_32bit_mul_i ? line_q[MUL32_LAT-1] : line_q[MUL16_LAT-1];
   assign ctl_vld = en_32bit_mul_i ? vld_line_q[MUL32_LAT-1] : vld_line_q[MUL16_LAT-1];

   always_comb
   begin
      prod = ctl.opmode.arith.mul_en ? mul_p : ctl.a;
      if (ctl.reduction)
         addend = acc_q;
      else if (ctl.opmode.arith.c_en)
         addend = ctl.c;
      else
         addend = '0;
      arith_res = ctl.opmode.arith.sub ? prod - addend : prod + addend;
      cmp_bit   = cmp_eval(ctl.opmode.cmp.cond, ctl.opmode.cmp.sgn, ctl.a, ctl.b);
      lane_res  = ctl.opmode.arith.cls ? {31'd0, cmp_bit} : arith_res;
   end

   // Result stage and running sum
   always_ff @(posedge clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         vld_o    <= 1'b0;
         result_o <= '0;
         acc_q    <= '0;
      end
      else if (!stall_i)
      begin
         vld_o <= ctl_vld;
         if (ctl_vld)
         begin
            result_o <= lane_res;
            // A plain op ends the reduction chain
            acc_q    <= ctl.reduction ? lane_res : '0;
         end
      end
   end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the ALU testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f build.f --top-module alu_tb -o alu_tb_sim
out=$(./obj_dir/alu_tb_sim)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "Simulation completed successfully"

//--- sim/alu_model.svh
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// Keep SEW low bits, fill upper bits with the element sign when signed
function automatic logic [31:0] ext_operand(input logic [31:0] v, input logic [1:0] sew,
                                            input logic s);
   logic [31:0] mask;
   logic        msb;
   case (sew)
      2'd0:    mask = 32'h0000_00ff;
      2'd1:    mask = 32'h0000_ffff;
      default: mask = 32'hffff_ffff;
   endcase
   msb = |(v & (mask ^ (mask >> 1)));
   if (s && msb)
      return (v & mask) | ~mask;
   return v & mask;
endfunction

// Narrow mode multiplies the low halves only
function automatic logic [31:0] product_model(input logic [31:0] a, input logic [31:0] b,
                                              input logic s, input logic wide);
   logic [63:0] fa;
   logic [63:0] fb;
   logic [63:0] full;
   fa = {48'd0, a[15:0]};
   fb = {48'd0, b[15:0]};
   if (wide)
   begin
      fa = {32'd0, a};
      fb = {32'd0, b};
   end
   else if (s)
   begin
      fa = {{48{a[15]}}, a[15:0]};
      fb = {{48{b[15]}}, b[15:0]};
   end
   full = fa * fb;
   return full[31:0];
endfunction

function automatic logic compare_model(input logic [2:0] cond, input logic s,
                                       input logic [31:0] a, input logic [31:0] b);
   logic signed [32:0] sa;
   logic signed [32:0] sb;
   sa = {s & a[31], a};
   sb = {s & b[31], b};
   case (cond)
      3'd0:    return sa == sb;
      3'd1:    return sa != sb;
      3'd2:    return sa < sb;
      3'd3:    return sa <= sb;
      3'd4:    return sa > sb;
      3'd5:    return sa >= sb;
      default: return 1'b0;
   endcase
endfunction

// Bit 8 is the class and bit 4 the signed flag in both opmode views
function automatic logic [31:0] element_model(input logic [8:0] op, input logic [31:0] a,
                                              input logic [31:0] b, input logic [31:0] c,
                                              input logic red, input logic [31:0] acc,
                                              input logic [1:0] sew, input logic wide);
   logic [31:0] ea;
   logic [31:0] eb;
   logic [31:0] p;
   logic [31:0] x;
   ea = ext_operand(a, sew, op[4]);
   eb = ext_operand(b, sew, op[4]);
   if (op[8])
      return {31'd0, compare_model(op[7:5], op[4], ea, eb)};
   p = op[7] ? product_model(ea, eb, op[4], wide) : ea;
   x = op[6] ? ext_operand(c, sew, op[4]) : 32'd0;
   if (red)
      x = acc;
   return op[5] ? p - x : p + x;
endfunction

function automatic logic [31:0] replicate_model(input logic [31:0] v, input logic [1:0] sew);
   case (sew)
      2'd0:    return {4{v[7:0]}};
      2'd1:    return {2{v[15:0]}};
      default: return v;
   endcase
endfunction

`endif

//--- sim/alu_tb.sv
`timescale 1ns/1ps

module alu_tb
   import alu_pkg::*;
();

   `include "alu_model.svh"

   localparam int NUM_LANES = 4;

   typedef struct packed
   {
      logic [31:0] elem;
      logic [31:0] tag;
   } expect_t;

   logic                       clk = 1'b0;
   logic                       rst_n_i;
   logic [NUM_LANES-1:0][8:0]  alu_opmode_i;
   logic [NUM_LANES-1:0][31:0] alu_a_i;
   logic [NUM_LANES-1:0][31:0] alu_b_i;
   logic [NUM_LANES-1:0][31:0] alu_c_i;
   sew_e                       sew_i;
   logic [NUM_LANES-1:0]       alu_reduction_i;
   logic [NUM_LANES-1:0]       alu_vld_i;
   logic                       alu_en_32bit_mul_i;
   logic                       alu_stall_i;
   logic [NUM_LANES-1:0][31:0] alu_o;
   logic [NUM_LANES-1:0]       alu_vld_o;
   logic [NUM_LANES-1:0]       alu_mask_vector_o;

   expect_t                    exp_q[NUM_LANES][$];
   logic [31:0]                acc_m[NUM_LANES] = '{default: '0};
   // Count of unstalled edges, used to tag issue and measure latency
   logic [31:0]                ucnt = '0;
   logic                       upd_q = 1'b0;
   logic [NUM_LANES-1:0][31:0] prev_o = '0;
   logic [NUM_LANES-1:0]       prev_vld = '0;
   logic [NUM_LANES-1:0]       prev_mask = '0;
   int                         mon_err = 0;
   int                         seq_err = 0;
   int                         checks = 0;
   int                         tests_ok = 0;
   int                         tests_bad = 0;

   alu #(.PARALLEL_IF_NUM(NUM_LANES)) uut (.*);

   initial
   begin
      forever
         #20 clk = ~clk;
   end

   task automatic issue_op(input int l);
      logic [31:0] res;
      res = element_model(alu_opmode_i[l], alu_a_i[l], alu_b_i[l], alu_c_i[l],
                          alu_reduction_i[l], acc_m[l], sew_i, alu_en_32bit_mul_i);
      acc_m[l] = alu_reduction_i[l] ? res : 32'd0;
      exp_q[l].push_back({res, ucnt});
   endtask

   task automatic check_lane(input int l);
      expect_t     e;
      logic [31:0] lat;
      lat = alu_en_32bit_mul_i ? 32'd4 : 32'd3;
      if (exp_q[l].size() == 0)
      begin
         $display("lane %0d gave a result at %0t ns with nothing pending", l, $time);
         mon_err++;
      end
      else
      begin
         e = exp_q[l].pop_front();
         checks++;
         assert (alu_o[l] == replicate_model(e.elem, sew_i))
         else
         begin
            $display("mismatch at %0t ns: lane %0d alu_o %h, expected %h", $time, l,
                     alu_o[l], replicate_model(e.elem, sew_i));
            mon_err++;
         end
         assert (alu_mask_vector_o[l] == e.elem[0])
         else
         begin
            $display("mismatch at %0t ns: lane %0d mask bit %b", $time, l, alu_mask_vector_o[l]);
            mon_err++;
         end
         assert (ucnt - e.tag == lat)
         else
         begin
            $display("mismatch at %0t ns: lane %0d latency %0d", $time, l, ucnt - e.tag);
            mon_err++;
         end
      end
   endtask

   // Issue on the rising edge as the DUT samples, check on the falling edge
   always @(clk)
   begin
      if (clk)
      begin
         upd_q = rst_n_i & ~alu_stall_i;
         if (upd_q)
         begin
            for (int l = 0; l < NUM_LANES; l++)
            begin
               if (alu_vld_i[l] && (l == 0 || !alu_en_32bit_mul_i))
                  issue_op(l);
            end
            ucnt = ucnt + 1;
         end
      end
      else
      begin
         if (rst_n_i && !upd_q)
         begin
            assert (alu_o == prev_o && alu_vld_o == prev_vld && alu_mask_vector_o == prev_mask)
            else
            begin
               $display("mismatch at %0t ns: outputs changed while stalled", $time);
               mon_err++;
            end
         end
         else if (rst_n_i)
         begin
            for (int l = 0; l < NUM_LANES; l++)
            begin
               if (alu_vld_o[l])
                  check_lane(l);
            end
         end
         prev_o    = alu_o;
         prev_vld  = alu_vld_o;
         prev_mask = alu_mask_vector_o;
      end
   end

   function automatic int pending_ops();
      int n;
      n = 0;
      for (int l = 0; l < NUM_LANES; l++)
         n += exp_q[l].size();
      return n;
   endfunction

   // cls_sel 0 is arithmetic, 1 compare, 2 either
   task automatic drive_cycle(input int cls_sel, input int red_pct, input int stall_pct);
      logic [31:0] r;
      logic [31:0] a;
      @(posedge clk);
      for (int l = 0; l < NUM_LANES; l++)
      begin
         r = $urandom;
         a = $urandom;
         alu_opmode_i[l]    <= {(cls_sel == 2) ? r[8] : cls_sel[0], r[7:0]};
         alu_a_i[l]         <= a;
         // Equal operands now and then so EQ and LE hit
         alu_b_i[l]         <= (r[31:30] == 2'd0) ? a : $urandom;
         alu_c_i[l]         <= $urandom;
         alu_reduction_i[l] <= $urandom_range(99, 0) < red_pct;
         alu_vld_i[l]       <= $urandom_range(99, 0) < 75;
      end
      alu_stall_i <= $urandom_range(99, 0) < stall_pct;
   endtask

   task automatic drain();
      int waited;
      waited = 0;
      @(posedge clk);
      alu_vld_i   <= '0;
      alu_stall_i <= 1'b0;
      while (pending_ops() != 0 && waited < 100)
      begin
         @(posedge clk);
         waited++;
      end
      if (pending_ops() != 0)
      begin
         $display("timeout: %0d results still missing after %0d cycles", pending_ops(), waited);
         seq_err++;
      end
      // Flush the valid shift line before a mode change
      repeat (5) @(posedge clk);
   endtask

   task automatic run_block(input int n, input int sew, input logic wide, input int cls_sel,
                            input int red_pct, input int stall_pct);
      @(posedge clk);
      sew_i              <= sew_e'(sew[1:0]);
      alu_en_32bit_mul_i <= wide;
      repeat (n)
         drive_cycle(cls_sel, red_pct, stall_pct);
      drain();
   endtask

   task automatic close_test(input string name, input int err_start);
      int e;
      e = mon_err + seq_err - err_start;
      if (e == 0)
         tests_ok++;
      else
         tests_bad++;
      $display("test %s: %s, %0d errors", name, (e == 0) ? "passed" : "FAILED", e);
   endtask

   initial
   begin
      int e0;
      void'($urandom(41295));
      rst_n_i            = 1'b0;
      alu_opmode_i       = '0;
      alu_a_i            = '0;
      alu_b_i            = '0;
      alu_c_i            = '0;
      sew_i              = SEW_8;
      alu_reduction_i    = '0;
      alu_vld_i          = '0;
      alu_en_32bit_mul_i = 1'b0;
      alu_stall_i        = 1'b0;
      repeat (8) @(posedge clk);
      rst_n_i <= 1'b1;

      e0 = mon_err + seq_err;
      @(negedge clk);
      assert (alu_vld_o == '0 && alu_o == '0 && alu_mask_vector_o == '0)
      else
      begin
         $display("mismatch at %0t ns: outputs not cleared after reset", $time);
         seq_err++;
      end
      close_test("1 reset state", e0);

      e0 = mon_err + seq_err;
      for (int s = 0; s < 4; s++)
         run_block(40, s, 1'b0, 0, 0, 0);
      close_test("2 arithmetic ops", e0);

      e0 = mon_err + seq_err;
      for (int s = 0; s < 4; s++)
         run_block(40, s, 1'b0, 1, 0, 0);
      close_test("3 compare ops", e0);

      e0 = mon_err + seq_err;
      for (int s = 0; s < 4; s++)
         run_block(40, s, 1'b0, 0, 75, 0);
      close_test("4 reduction chains", e0);

      e0 = mon_err + seq_err;
      for (int s = 0; s < 4; s++)
         run_block(50, s, 1'b0, 2, 30, 15);
      close_test("5 random stalls", e0);

      e0 = mon_err + seq_err;
      run_block(80, 2, 1'b1, 2, 30, 15);
      close_test("6 wide multiply", e0);

      $display("tests passed %0d, failed %0d, result checks %0d, errors %0d",
               tests_ok, tests_bad, checks, mon_err + seq_err);
      if (mon_err + seq_err == 0)
         $display("Simulation completed successfully");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule
